/* hdl/dma_sink_pkg.sv */
// dma sink definitions
package dma_sink_pkg;

    localparam int LEN_W = 16;
    localparam int TAG_W = 8;
    localparam int ADDR_W = 12;
    localparam int SEGS = 2;
    localparam int SEG_DATA_W = 16;
    localparam int SEG_BE_W = 2;
    localparam int SEG_ADDR_W = 10;
    localparam int DATA_W = 32;
    localparam int KEEP_W = 4;
    localparam int STATUS_FIFO_AW = 4;
    localparam int OUT_FIFO_AW = 4;

    typedef logic [LEN_W-1:0] len_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [ADDR_W-1:0] ram_addr_t;
    typedef logic [SEG_ADDR_W-1:0] seg_addr_t;
    typedef logic [SEG_DATA_W-1:0] seg_data_t;
    typedef logic [SEG_BE_W-1:0] seg_be_t;
    typedef logic [SEGS-1:0] seg_mask_t;
    typedef logic [DATA_W-1:0] stream_data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_drop
    } write_state_t;

endpackage

/* hdl/seg_write_queue.sv */
// segment RAM write queue
`timescale 1ns/1ns

module seg_write_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  dma_sink_pkg::seg_be_t   cmd_be,
    input  dma_sink_pkg::seg_addr_t cmd_addr,
    input  dma_sink_pkg::seg_data_t cmd_data,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    output dma_sink_pkg::seg_be_t   ram_wr_be,
    output dma_sink_pkg::seg_addr_t ram_wr_addr,
    output dma_sink_pkg::seg_data_t ram_wr_data,
    output logic                    ram_wr_valid,
    input  logic                    ram_wr_ready,
    input  logic                    ram_wr_done,
    input  logic                    done_ack,
    output logic                    seg_done
);

    dma_sink_pkg::seg_be_t   fifo_be[2**dma_sink_pkg::OUT_FIFO_AW];
    dma_sink_pkg::seg_addr_t fifo_addr[2**dma_sink_pkg::OUT_FIFO_AW];
    dma_sink_pkg::seg_data_t fifo_data[2**dma_sink_pkg::OUT_FIFO_AW];

    logic [dma_sink_pkg::OUT_FIFO_AW:0] wr_ptr;
    logic [dma_sink_pkg::OUT_FIFO_AW:0] rd_ptr;
    logic [dma_sink_pkg::OUT_FIFO_AW:0] fill;
    logic [dma_sink_pkg::OUT_FIFO_AW:0] done_count;
    logic                               half_full_q;
    logic                               full;
    logic                               empty;
    logic                               push;
    logic                               pop;

    assign fill = wr_ptr - rd_ptr;
    assign full = fill[dma_sink_pkg::OUT_FIFO_AW];
    assign empty = fill == '0;
    assign push = cmd_valid && !full;
    // refill the port when it is idle or its command is being taken
    assign pop = !empty && (!ram_wr_valid || ram_wr_ready);
    assign cmd_ready = !half_full_q;
    assign seg_done = done_count != '0;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_be[wr_ptr[dma_sink_pkg::OUT_FIFO_AW-1:0]] <= cmd_be;
            fifo_addr[wr_ptr[dma_sink_pkg::OUT_FIFO_AW-1:0]] <= cmd_addr;
            fifo_data[wr_ptr[dma_sink_pkg::OUT_FIFO_AW-1:0]] <= cmd_data;
        end
        if (pop) begin
            ram_wr_be <= fifo_be[rd_ptr[dma_sink_pkg::OUT_FIFO_AW-1:0]];
            ram_wr_addr <= fifo_addr[rd_ptr[dma_sink_pkg::OUT_FIFO_AW-1:0]];
            ram_wr_data <= fifo_data[rd_ptr[dma_sink_pkg::OUT_FIFO_AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            half_full_q <= 1'b0;
            ram_wr_valid <= 1'b0;
            done_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                ram_wr_valid <= 1'b1;
            end else if (ram_wr_ready) begin
                ram_wr_valid <= 1'b0;
            end
            half_full_q <= fill >= 2**(dma_sink_pkg::OUT_FIFO_AW-1);
            if (ram_wr_done && !done_ack) begin
                done_count <= done_count + 1'b1;
            end else if (!ram_wr_done && done_ack) begin
                done_count <= done_count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> !full);

    a_ack_has_done: assert property (@(posedge clk) disable iff (rst)
        done_ack |-> seg_done);

endmodule

/* hdl/completion_tracker.sv */
// in-order completion tracker
`timescale 1ns/1ns

module completion_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    ent_valid,
    input  dma_sink_pkg::len_t      ent_len,
    input  dma_sink_pkg::tag_t      ent_tag,
    input  dma_sink_pkg::seg_mask_t ent_mask,
    input  logic                    ent_last,
    input  dma_sink_pkg::seg_mask_t seg_done,
    output dma_sink_pkg::seg_mask_t done_ack,
    output logic                    credit_ok,
    output logic                    status_hold,
    output logic                    sts_valid,
    output dma_sink_pkg::len_t      sts_len,
    output dma_sink_pkg::tag_t      sts_tag
);

    dma_sink_pkg::len_t      fifo_len[2**dma_sink_pkg::STATUS_FIFO_AW];
    dma_sink_pkg::tag_t      fifo_tag[2**dma_sink_pkg::STATUS_FIFO_AW];
    dma_sink_pkg::seg_mask_t fifo_mask[2**dma_sink_pkg::STATUS_FIFO_AW];
    logic                    fifo_last[2**dma_sink_pkg::STATUS_FIFO_AW];

    logic [dma_sink_pkg::STATUS_FIFO_AW:0]   wr_ptr;
    logic [dma_sink_pkg::STATUS_FIFO_AW:0]   rd_ptr;
    logic [dma_sink_pkg::STATUS_FIFO_AW:0]   fill;
    logic [dma_sink_pkg::STATUS_FIFO_AW:0]   active_count;
    logic [dma_sink_pkg::STATUS_FIFO_AW-1:0] head;
    logic                                    full;
    logic                                    empty;
    logic                                    retire;
    logic                                    finish;

    assign head = rd_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0];
    assign fill = wr_ptr - rd_ptr;
    assign full = fill[dma_sink_pkg::STATUS_FIFO_AW];
    assign empty = fill == '0;
    // head retires once every segment it wrote has a completion waiting
    assign retire = !empty && ((fifo_mask[head] & ~seg_done) == '0);
    assign finish = retire && fifo_last[head];
    assign done_ack = retire ? fifo_mask[head] : '0;
    // fewer than 16 transfers in flight
    assign credit_ok = !active_count[dma_sink_pkg::STATUS_FIFO_AW];

    always_ff @(posedge clk) begin
        if (ent_valid) begin
            fifo_len[wr_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0]] <= ent_len;
            fifo_tag[wr_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0]] <= ent_tag;
            fifo_mask[wr_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0]] <= ent_mask;
            fifo_last[wr_ptr[dma_sink_pkg::STATUS_FIFO_AW-1:0]] <= ent_last;
        end
        sts_len <= fifo_len[head];
        sts_tag <= fifo_tag[head];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            active_count <= '0;
            status_hold <= 1'b0;
            sts_valid <= 1'b0;
        end else begin
            if (ent_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            status_hold <= fill >= 2**(dma_sink_pkg::STATUS_FIFO_AW-1);
            sts_valid <= finish;
            if (start && !finish) begin
                active_count <= active_count + 1'b1;
            end else if (!start && finish) begin
                active_count <= active_count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        ent_valid |-> !full);

endmodule

/* hdl/write_ctrl.sv */
// descriptor and stream write controller
`timescale 1ns/1ns

module write_ctrl (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             enable,
    input  logic                                             desc_valid,
    output logic                                             desc_ready,
    input  dma_sink_pkg::ram_addr_t                          desc_addr,
    input  dma_sink_pkg::len_t                               desc_len,
    input  dma_sink_pkg::tag_t                               desc_tag,
    input  dma_sink_pkg::stream_data_t                       s_tdata,
    input  dma_sink_pkg::keep_t                              s_tkeep,
    input  logic                                             s_tlast,
    input  logic                                             s_tvalid,
    output logic                                             s_tready,
    input  logic                                             credit_ok,
    input  logic                                             status_hold,
    input  dma_sink_pkg::seg_mask_t                          cmd_ready,
    output dma_sink_pkg::seg_be_t   [dma_sink_pkg::SEGS-1:0] cmd_be,
    output dma_sink_pkg::seg_addr_t [dma_sink_pkg::SEGS-1:0] cmd_addr,
    output dma_sink_pkg::seg_data_t [dma_sink_pkg::SEGS-1:0] cmd_data,
    output dma_sink_pkg::seg_mask_t                          cmd_valid,
    output logic                                             start,
    output logic                                             ent_valid,
    output dma_sink_pkg::len_t                               ent_len,
    output dma_sink_pkg::tag_t                               ent_tag,
    output dma_sink_pkg::seg_mask_t                          ent_mask,
    output logic                                             ent_last
);

    dma_sink_pkg::write_state_t state_q;

    dma_sink_pkg::ram_addr_t addr_q;
    dma_sink_pkg::len_t      length_q;
    dma_sink_pkg::len_t      beats_left_q;
    logic                    last_beat_q;
    dma_sink_pkg::keep_t     keep_mask_q;
    dma_sink_pkg::keep_t     last_mask_q;
    dma_sink_pkg::tag_t      tag_q;

    dma_sink_pkg::len_t      desc_last_idx;
    dma_sink_pkg::keep_t     desc_last_mask;
    dma_sink_pkg::keep_t     keep_eff;
    dma_sink_pkg::seg_mask_t seg_mask;
    logic                    desc_fire;
    logic                    beat_fire;
    logic                    writing;

    assign desc_fire = desc_valid && desc_ready;
    assign beat_fire = s_tvalid && s_tready;
    assign writing = beat_fire && (state_q == dma_sink_pkg::st_write);

    // index of the final beat and the lanes it keeps
    always_comb begin
        desc_last_idx = (desc_len - dma_sink_pkg::len_t'(1)) >> 2;
        for (int i = 0; i < dma_sink_pkg::KEEP_W; i++) begin
            desc_last_mask[i] = (desc_len[1:0] == 2'd0) || (i < int'(desc_len[1:0]));
        end
    end

    // full-width beat, so each segment takes its own lanes unshifted
    always_comb begin
        keep_eff = s_tkeep & keep_mask_q;
        for (int s = 0; s < dma_sink_pkg::SEGS; s++) begin
            cmd_be[s] = keep_eff[s*dma_sink_pkg::SEG_BE_W +: dma_sink_pkg::SEG_BE_W];
            cmd_addr[s] = addr_q[dma_sink_pkg::ADDR_W-1 -: dma_sink_pkg::SEG_ADDR_W];
            cmd_data[s] = s_tdata[s*dma_sink_pkg::SEG_DATA_W +: dma_sink_pkg::SEG_DATA_W];
            seg_mask[s] = |cmd_be[s];
        end
    end

    assign start = desc_fire;
    assign cmd_valid = writing ? seg_mask : '0;
    assign ent_valid = writing;
    assign ent_tag = tag_q;
    assign ent_mask = seg_mask;
    assign ent_last = s_tlast || last_beat_q;
    // tlast counts the kept lanes, otherwise the length mask decides
    assign ent_len = length_q + dma_sink_pkg::len_t'($countones(s_tlast ? keep_eff : keep_mask_q));

    always_ff @(posedge clk) begin
        if (state_q == dma_sink_pkg::st_idle) begin
            addr_q <= {desc_addr[dma_sink_pkg::ADDR_W-1:2], 2'b00};
            length_q <= '0;
            beats_left_q <= desc_last_idx;
            last_beat_q <= desc_last_idx == '0;
            keep_mask_q <= (desc_last_idx == '0) ? desc_last_mask : '1;
            last_mask_q <= desc_last_mask;
            tag_q <= desc_tag;
        end else if (writing) begin
            addr_q <= addr_q + dma_sink_pkg::ram_addr_t'(dma_sink_pkg::KEEP_W);
            length_q <= length_q + dma_sink_pkg::len_t'(dma_sink_pkg::KEEP_W);
            beats_left_q <= beats_left_q - dma_sink_pkg::len_t'(1);
            last_beat_q <= beats_left_q == dma_sink_pkg::len_t'(1);
            keep_mask_q <= (beats_left_q == dma_sink_pkg::len_t'(1)) ? last_mask_q : '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dma_sink_pkg::st_idle;
            desc_ready <= 1'b0;
            s_tready <= 1'b0;
        end else begin
            case (state_q)
                dma_sink_pkg::st_idle: begin
                    desc_ready <= enable && credit_ok;
                    if (desc_fire) begin
                        desc_ready <= 1'b0;
                        s_tready <= &cmd_ready && !status_hold;
                        state_q <= dma_sink_pkg::st_write;
                    end
                end
                dma_sink_pkg::st_write: begin
                    s_tready <= &cmd_ready && !status_hold;
                    if (beat_fire && s_tlast) begin
                        s_tready <= 1'b0;
                        desc_ready <= enable && credit_ok;
                        state_q <= dma_sink_pkg::st_idle;
                    end else if (beat_fire && last_beat_q) begin
                        s_tready <= 1'b1;
                        state_q <= dma_sink_pkg::st_drop;
                    end
                end
                dma_sink_pkg::st_drop: begin
                    // length used up, swallow beats until tlast
                    s_tready <= 1'b1;
                    if (beat_fire && s_tlast) begin
                        s_tready <= 1'b0;
                        desc_ready <= enable && credit_ok;
                        state_q <= dma_sink_pkg::st_idle;
                    end
                end
                default: begin
                    state_q <= dma_sink_pkg::st_idle;
                end
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state_q inside {dma_sink_pkg::st_idle, dma_sink_pkg::st_write, dma_sink_pkg::st_drop});

endmodule

/* hdl/dma_sink_top.sv */
// dma stream sink top level
`timescale 1ns/1ns

module dma_sink_top (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             enable,
    input  logic                                             desc_valid,
    output logic                                             desc_ready,
    input  dma_sink_pkg::ram_addr_t                          desc_addr,
    input  dma_sink_pkg::len_t                               desc_len,
    input  dma_sink_pkg::tag_t                               desc_tag,
    input  dma_sink_pkg::stream_data_t                       s_tdata,
    input  dma_sink_pkg::keep_t                              s_tkeep,
    input  logic                                             s_tlast,
    input  logic                                             s_tvalid,
    output logic                                             s_tready,
    output dma_sink_pkg::seg_be_t   [dma_sink_pkg::SEGS-1:0] ram_wr_be,
    output dma_sink_pkg::seg_addr_t [dma_sink_pkg::SEGS-1:0] ram_wr_addr,
    output dma_sink_pkg::seg_data_t [dma_sink_pkg::SEGS-1:0] ram_wr_data,
    output dma_sink_pkg::seg_mask_t                          ram_wr_valid,
    input  dma_sink_pkg::seg_mask_t                          ram_wr_ready,
    input  dma_sink_pkg::seg_mask_t                          ram_wr_done,
    output logic                                             sts_valid,
    output dma_sink_pkg::len_t                               sts_len,
    output dma_sink_pkg::tag_t                               sts_tag
);

    dma_sink_pkg::seg_be_t   [dma_sink_pkg::SEGS-1:0] cmd_be;
    dma_sink_pkg::seg_addr_t [dma_sink_pkg::SEGS-1:0] cmd_addr;
    dma_sink_pkg::seg_data_t [dma_sink_pkg::SEGS-1:0] cmd_data;
    dma_sink_pkg::seg_mask_t cmd_valid;
    dma_sink_pkg::seg_mask_t cmd_ready;
    dma_sink_pkg::seg_mask_t seg_done;
    dma_sink_pkg::seg_mask_t done_ack;

    logic                    start;
    logic                    credit_ok;
    logic                    status_hold;
    logic                    ent_valid;
    dma_sink_pkg::len_t      ent_len;
    dma_sink_pkg::tag_t      ent_tag;
    dma_sink_pkg::seg_mask_t ent_mask;
    logic                    ent_last;

    write_ctrl u_write_ctrl (.*);

    completion_tracker u_completion_tracker (.*);

    // one command queue per RAM write segment
    for (genvar g = 0; g < dma_sink_pkg::SEGS; g++) begin : g_seg
        seg_write_queue u_seg_write_queue (
            .clk          (clk),
            .rst          (rst),
            .cmd_be       (cmd_be[g]),
            .cmd_addr     (cmd_addr[g]),
            .cmd_data     (cmd_data[g]),
            .cmd_valid    (cmd_valid[g]),
            .cmd_ready    (cmd_ready[g]),
            .ram_wr_be    (ram_wr_be[g]),
            .ram_wr_addr  (ram_wr_addr[g]),
            .ram_wr_data  (ram_wr_data[g]),
            .ram_wr_valid (ram_wr_valid[g]),
            .ram_wr_ready (ram_wr_ready[g]),
            .ram_wr_done  (ram_wr_done[g]),
            .done_ack     (done_ack[g]),
            .seg_done     (seg_done[g])
        );
    end

endmodule

/* verif/tb_clock_gen.sv */
// testbench clock and reset
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 rst = 1'b0;
    end

endmodule

/* verif/tb_dma_sink.sv */
// dma sink testbench
`timescale 1ns/1ns

module tb_dma_sink;

    localparam int SEED = 32'h250f;
    localparam int MAX_BEATS = 345;
    localparam int WATCHDOG_NS = MAX_BEATS * 40 * 20 + 100000;
    localparam int WAIT_LIMIT = 5000;
    localparam int MEM_BYTES = 1 << dma_sink_pkg::ADDR_W;

    logic clk;
    logic rst;
    logic enable;
    logic desc_valid;
    logic desc_ready;
    dma_sink_pkg::ram_addr_t desc_addr;
    dma_sink_pkg::len_t desc_len;
    dma_sink_pkg::tag_t desc_tag;
    dma_sink_pkg::stream_data_t s_tdata;
    dma_sink_pkg::keep_t s_tkeep;
    logic s_tlast;
    logic s_tvalid;
    logic s_tready;
    dma_sink_pkg::seg_be_t [dma_sink_pkg::SEGS-1:0] ram_wr_be;
    dma_sink_pkg::seg_addr_t [dma_sink_pkg::SEGS-1:0] ram_wr_addr;
    dma_sink_pkg::seg_data_t [dma_sink_pkg::SEGS-1:0] ram_wr_data;
    dma_sink_pkg::seg_mask_t ram_wr_valid;
    dma_sink_pkg::seg_mask_t ram_wr_ready = '0;
    dma_sink_pkg::seg_mask_t ram_wr_done = '0;
    logic sts_valid;
    dma_sink_pkg::len_t sts_len;
    dma_sink_pkg::tag_t sts_tag;

    logic [7:0] mem [MEM_BYTES];
    logic [7:0] exp_mem [MEM_BYTES];
    int pending [dma_sink_pkg::SEGS];
    int done_wait [dma_sink_pkg::SEGS];
    int ready_pct = 75;
    int done_max = 3;
    int value_errors = 0;
    int wait_errors = 0;

    dma_sink_pkg::stream_data_t beat_data[$];
    dma_sink_pkg::keep_t beat_keep[$];
    logic beat_last[$];
    dma_sink_pkg::ram_addr_t desc_q_addr[$];
    dma_sink_pkg::len_t desc_q_len[$];
    dma_sink_pkg::tag_t desc_q_tag[$];
    dma_sink_pkg::len_t exp_len[$];
    dma_sink_pkg::tag_t exp_tag[$];

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    dma_sink_top u_dut (.*);

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a ^ (a >> 8) ^ 32'h5a);
    endfunction

    // RAM model with random ready and in-order done after a random gap
    always @(posedge clk) begin
        int a;
        if (rst) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] = fill_byte(i);
            end
            for (int s = 0; s < dma_sink_pkg::SEGS; s++) begin
                pending[s] = 0;
                done_wait[s] = 0;
            end
        end else begin
            for (int s = 0; s < dma_sink_pkg::SEGS; s++) begin
                if (ram_wr_valid[s] && ram_wr_ready[s]) begin
                    for (int b = 0; b < dma_sink_pkg::SEG_BE_W; b++) begin
                        a = int'(ram_wr_addr[s]) * 4 + s * 2 + b;
                        if (ram_wr_be[s][b]) begin
                            mem[a] = ram_wr_data[s][8*b +: 8];
                        end
                    end
                    pending[s]++;
                end
            end
        end
        #5;
        for (int s = 0; s < dma_sink_pkg::SEGS; s++) begin
            ram_wr_ready[s] = !rst && (int'($urandom_range(99)) < ready_pct);
            ram_wr_done[s] = 1'b0;
            if (pending[s] > 0) begin
                if (done_wait[s] == 0) begin
                    ram_wr_done[s] = 1'b1;
                    pending[s]--;
                    done_wait[s] = int'($urandom_range(done_max));
                end else begin
                    done_wait[s]--;
                end
            end
        end
    end

    task automatic check_len(input dma_sink_pkg::len_t got, input dma_sink_pkg::len_t want,
                             input string what);
        if (got !== want) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, want);
            value_errors++;
        end
    endtask

    task automatic check_tag(input dma_sink_pkg::tag_t got, input dma_sink_pkg::tag_t want,
                             input string what);
        if (got !== want) begin
            $display("FAIL %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, want);
            value_errors++;
        end
    endtask

    task automatic check_word(input dma_sink_pkg::seg_data_t got,
                              input dma_sink_pkg::seg_data_t want, input int byte_addr);
        if (got !== want) begin
            $display("FAIL %0t: RAM at 0x%03h holds 0x%04h, expected 0x%04h",
                     $time, byte_addr, got, want);
            value_errors++;
        end
    endtask

    // len is the descriptor length and stream_bytes places tlast
    task automatic queue_transfer(input int addr, input int len, input int stream_bytes,
                                  input int tag);
        int written;
        int nbeats;
        int base;
        int remaining;
        dma_sink_pkg::stream_data_t data;
        dma_sink_pkg::keep_t keep;
        written = (len < stream_bytes) ? len : stream_bytes;
        nbeats = (stream_bytes + 3) / 4;
        base = addr & ~3;
        for (int i = 0; i < nbeats; i++) begin
            data = $urandom;
            remaining = stream_bytes - 4 * i;
            for (int b = 0; b < dma_sink_pkg::KEEP_W; b++) begin
                if (4 * i + b < written) begin
                    exp_mem[base + 4 * i + b] = data[8*b +: 8];
                end
            end
            keep = (remaining >= 4) ? 4'hf : dma_sink_pkg::keep_t'((1 << remaining) - 1);
            beat_data.push_back(data);
            beat_keep.push_back(keep);
            beat_last.push_back(i == nbeats - 1);
        end
        desc_q_addr.push_back(dma_sink_pkg::ram_addr_t'(addr));
        desc_q_len.push_back(dma_sink_pkg::len_t'(len));
        desc_q_tag.push_back(dma_sink_pkg::tag_t'(tag));
        exp_len.push_back(dma_sink_pkg::len_t'(written));
        exp_tag.push_back(dma_sink_pkg::tag_t'(tag));
    endtask

    task automatic drive_descs();
        int waited;
        logic taken;
        while (desc_q_addr.size() > 0) begin
            desc_valid = 1'b1;
            desc_addr = desc_q_addr.pop_front();
            desc_len = desc_q_len.pop_front();
            desc_tag = desc_q_tag.pop_front();
            waited = 0;
            taken = 1'b0;
            while (!taken && waited < WAIT_LIMIT) begin
                @(posedge clk);
                taken = desc_ready;
                waited++;
            end
            #5;
            if (!taken) begin
                $display("timed out waiting for the DUT to take a descriptor");
                wait_errors++;
                desc_q_addr.delete();
                desc_q_len.delete();
                desc_q_tag.delete();
            end
        end
        desc_valid = 1'b0;
    endtask

    task automatic drive_stream();
        int waited;
        logic taken;
        while (beat_data.size() > 0) begin
            s_tvalid = 1'b1;
            s_tdata = beat_data.pop_front();
            s_tkeep = beat_keep.pop_front();
            s_tlast = beat_last.pop_front();
            waited = 0;
            taken = 1'b0;
            while (!taken && waited < WAIT_LIMIT) begin
                @(posedge clk);
                taken = s_tready;
                waited++;
            end
            #5;
            if (!taken) begin
                $display("timed out waiting for the DUT to take a stream beat");
                wait_errors++;
                beat_data.delete();
                beat_keep.delete();
                beat_last.delete();
            end
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
    endtask

    task automatic collect_status();
        int waited;
        waited = 0;
        while (exp_len.size() > 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            if (sts_valid) begin
                check_len(sts_len, exp_len.pop_front(), "status length");
                check_tag(sts_tag, exp_tag.pop_front(), "status tag");
                waited = 0;
            end
        end
        if (exp_len.size() > 0) begin
            $display("timed out waiting for status, %0d transfers never completed",
                     exp_len.size());
            wait_errors++;
            exp_len.delete();
            exp_tag.delete();
        end
    endtask

    task automatic run_queued();
        fork
            drive_descs();
            drive_stream();
            collect_status();
        join
        #5;
        for (int w = 0; w < MEM_BYTES / 2; w++) begin
            check_word({mem[2*w+1], mem[2*w]}, {exp_mem[2*w+1], exp_mem[2*w]}, 2 * w);
        end
    endtask

    task automatic gate_on_enable();
        int high_cycles;
        high_cycles = 0;
        repeat (20) begin
            @(posedge clk);
            if (desc_ready) begin
                high_cycles++;
            end
        end
        #5;
        if (high_cycles != 0) begin
            $display("FAIL %0t: desc_ready high for %0d cycles with enable low",
                     $time, high_cycles);
            value_errors++;
        end
        enable = 1'b1;
        queue_transfer('h100, 32, 32, 'h11);
        run_queued();
    endtask

    task automatic mask_partial_beat();
        queue_transfer('h200, 13, 16, 'h22);
        run_queued();
    endtask

    task automatic end_on_tlast();
        queue_transfer('h300, 40, 22, 'h33);
        run_queued();
    endtask

    // second transfer lands where undropped beats would have gone
    task automatic drop_excess_beats();
        queue_transfer('h400, 8, 20, 'h44);
        queue_transfer('h408, 8, 8, 'h45);
        run_queued();
    endtask

    task automatic queue_under_backpressure();
        ready_pct = 30;
        done_max = 8;
        for (int i = 0; i < 20; i++) begin
            queue_transfer(int'($urandom_range(MEM_BYTES - 128)), int'($urandom_range(64, 1)),
                           int'($urandom_range(64, 1)), 'h80 + i);
        end
        run_queued();
        ready_pct = 75;
        done_max = 3;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        enable = 1'b0;
        desc_valid = 1'b0;
        desc_addr = '0;
        desc_len = '0;
        desc_tag = '0;
        s_tdata = '0;
        s_tkeep = '0;
        s_tlast = 1'b0;
        s_tvalid = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            exp_mem[i] = fill_byte(i);
        end
        wait (rst == 1'b0);
        @(posedge clk);
        #5;
        gate_on_enable();
        mask_partial_beat();
        end_on_tlast();
        drop_excess_beats();
        queue_under_backpressure();
        $display("errors: %0d value mismatches, %0d timeouts", value_errors, wait_errors);
        if (value_errors == 0 && wait_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* dma_sink.f */
hdl/dma_sink_pkg.sv
hdl/seg_write_queue.sv
hdl/completion_tracker.sv
hdl/write_ctrl.sv
hdl/dma_sink_top.sv
verif/tb_clock_gen.sv
verif/tb_dma_sink.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dma_sink
FILELIST  ?= dma_sink.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
